// File: verilog/hpu_pkg.sv
// widths, register map, controller states and descriptor structs of the hpu cluster
`default_nettype none

package hpu_pkg;

    localparam int unsigned APB_ADDR_W = 8;
    localparam int unsigned DATA_W     = 32;

    // one word per register, byte offsets
    typedef enum logic [APB_ADDR_W-1:0] {
        REG_HANDLER_FUN  = 8'h00,
        REG_HANDLER_MEM  = 8'h04,
        REG_PKT_PTR      = 8'h08,
        REG_PKT_SIZE     = 8'h0C,
        REG_HOST_ADDR_HI = 8'h10,
        REG_HOST_ADDR_LO = 8'h14,
        REG_PKT_ADDR     = 8'h18,
        REG_HOME_CLUSTER = 8'h1C,
        REG_MSGID        = 8'h20,
        REG_FEEDBACK     = 8'h24  // read ends the handler
    } reg_addr_e;

    typedef enum logic [1:0] {
        ST_INIT,      // core not yet attached
        ST_IDLE,
        ST_RUNNING,
        ST_FEEDBACK   // null handler, feedback without the core
    } handler_state_e;

    // task as handed over by the scheduler
    typedef struct packed {
        logic [31:0] handler_fun;
        logic [31:0] handler_mem_addr;
        logic [31:0] pkt_ptr;           // L1 address
        logic [31:0] pkt_size;
        logic [63:0] host_mem_addr;
        logic [31:0] pkt_addr;          // L2 address
        logic [31:0] msgid;
        logic        trigger_feedback;
    } handler_task_t;

    // what goes back once the handler is done
    typedef struct packed {
        logic [31:0] pkt_ptr;
        logic [31:0] pkt_addr;
        logic [31:0] msgid;
        logic [31:0] pkt_size;
        logic        trigger_feedback;
    } feedback_t;

endpackage

`default_nettype wire

// File: verilog/hpu_task_dispatch.sv
// round-robin dispatcher handing each incoming task to one idle handler controller
`default_nettype none

module hpu_task_dispatch #(
    parameter int unsigned NUM_HPUS = 4
) (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,

    input  wire logic                task_valid_i,
    output logic                     task_ready_o,

    input  wire logic [NUM_HPUS-1:0] idle_i,
    output logic      [NUM_HPUS-1:0] task_valid_o
);

    localparam int unsigned IDX_W = (NUM_HPUS > 1) ? $clog2(NUM_HPUS) : 1;

    logic [IDX_W-1:0] ptr_q;     // first candidate for the next task
    logic [IDX_W-1:0] ptr_next;
    logic [IDX_W-1:0] sel;
    logic             found;
    logic             task_xfer;

    // first idle controller at or after the pointer, wrapping around
    always_comb begin
        int unsigned cand;
        cand  = 0;
        found = 1'b0;
        sel   = '0;
        for (int unsigned i = 0; i < NUM_HPUS; i++) begin
            cand = (int'(ptr_q) + i) % NUM_HPUS;
            if (!found && idle_i[cand]) begin
                found = 1'b1;
                sel   = IDX_W'(cand);
            end
        end
    end

    assign task_ready_o = |idle_i;
    assign task_xfer    = task_valid_i && task_ready_o;

    // one-hot valid toward the chosen controller only
    always_comb begin
        task_valid_o = '0;
        if (task_valid_i && found) begin
            task_valid_o[sel] = 1'b1;
        end
    end

    // pointer moves past the controller that got the task
    always_comb begin
        if (sel == IDX_W'(NUM_HPUS - 1)) begin
            ptr_next = '0;
        end else begin
            ptr_next = sel + 1'b1;
        end
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (task_xfer) begin
            ptr_q <= ptr_next;
        end
    end

endmodule

`default_nettype wire

// File: verilog/hpu_handler_ctrl.sv
// handler controller with state machine, apb task registers and one-entry feedback buffer
`default_nettype none

module hpu_handler_ctrl #(
    parameter int unsigned NUM_CLUSTERS = 4
) (
    input  wire logic                            clk_i,
    input  wire logic                            rst_ni,

    // task from the dispatcher
    input  wire logic                            task_valid_i,
    input  wire hpu_pkg::handler_task_t          task_i,
    output logic                                 idle_o,
    output logic                                 active_o,

    // apb slave toward the core
    input  wire logic                            psel_i,
    input  wire logic                            penable_i,
    input  wire logic                            pwrite_i,
    input  wire logic [hpu_pkg::APB_ADDR_W-1:0]  paddr_i,
    input  wire logic [hpu_pkg::DATA_W-1:0]      pwdata_i,
    output logic      [hpu_pkg::DATA_W-1:0]      prdata_o,
    output logic                                 pready_o,
    output logic                                 pslverr_o,

    // feedback toward the arbiter
    output logic                                 fb_valid_o,
    output hpu_pkg::feedback_t                   fb_o,
    input  wire logic                            fb_ready_i
);

    import hpu_pkg::*;

    localparam int unsigned CL_W = (NUM_CLUSTERS > 1) ? $clog2(NUM_CLUSTERS) : 1;

    handler_state_e state_q, state_d;

    handler_task_t  task_q;       // task of the running handler
    feedback_t      fb_q;
    feedback_t      fb_d;
    logic           fb_valid_q;

    logic           apb_access;
    logic           fb_space;
    logic           fb_push;
    logic           fb_pop;
    logic           task_accept;
    reg_addr_e      reg_addr;
    logic [CL_W-1:0] home_cluster;

    assign apb_access  = psel_i && penable_i;
    assign reg_addr    = reg_addr_e'(paddr_i);
    assign task_accept = (state_q == ST_IDLE) && task_valid_i;

    assign idle_o   = (state_q == ST_IDLE);
    assign active_o = (state_q != ST_INIT);

    // home cluster is encoded in the low msgid bits
    assign home_cluster = task_q.msgid[CL_W-1:0];

    // a pop in the same cycle frees the slot for a new push
    assign fb_pop   = fb_valid_q && fb_ready_i;
    assign fb_space = !fb_valid_q || fb_ready_i;

    assign fb_d.pkt_ptr          = task_q.pkt_ptr;
    assign fb_d.pkt_addr         = task_q.pkt_addr;
    assign fb_d.msgid            = task_q.msgid;
    assign fb_d.pkt_size         = task_q.pkt_size;
    assign fb_d.trigger_feedback = task_q.trigger_feedback;

    assign fb_valid_o = fb_valid_q;
    assign fb_o       = fb_q;

    // next state and apb response
    always_comb begin
        state_d   = state_q;
        prdata_o  = '0;
        pready_o  = 1'b1;
        pslverr_o = 1'b0;
        fb_push   = 1'b0;

        case (state_q)
            ST_INIT: begin
                // first access from the core attaches it, reads back 0
                if (apb_access) begin
                    state_d = ST_IDLE;
                end
            end

            ST_IDLE: begin
                pslverr_o = 1'b1;   // nothing to read without a handler
                if (task_valid_i) begin
                    if (task_i.handler_fun == '0) begin
                        state_d = ST_FEEDBACK;
                    end else begin
                        state_d = ST_RUNNING;
                    end
                end
            end

            ST_RUNNING: begin
                if (pwrite_i) begin
                    pslverr_o = 1'b1;   // register map is read only
                end else begin
                    case (reg_addr)
                        REG_HANDLER_FUN:  prdata_o = task_q.handler_fun;
                        REG_HANDLER_MEM:  prdata_o = task_q.handler_mem_addr;
                        REG_PKT_PTR:      prdata_o = task_q.pkt_ptr;
                        REG_PKT_SIZE:     prdata_o = task_q.pkt_size;
                        REG_HOST_ADDR_HI: prdata_o = task_q.host_mem_addr[63:32];
                        REG_HOST_ADDR_LO: prdata_o = task_q.host_mem_addr[31:0];
                        REG_PKT_ADDR:     prdata_o = task_q.pkt_addr;
                        REG_HOME_CLUSTER: prdata_o = {{(DATA_W-CL_W){1'b0}}, home_cluster};
                        REG_MSGID:        prdata_o = task_q.msgid;
                        REG_FEEDBACK: begin
                            // stall the core while the old feedback is still queued
                            pready_o = fb_space;
                            if (apb_access && fb_space) begin
                                fb_push = 1'b1;
                                state_d = ST_IDLE;
                            end
                        end
                        default: pslverr_o = 1'b1;
                    endcase
                end
            end

            ST_FEEDBACK: begin
                pslverr_o = 1'b1;
                if (fb_space) begin
                    fb_push = 1'b1;
                    state_d = ST_IDLE;
                end
            end

            default: state_d = ST_INIT;
        endcase
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= ST_INIT;
            fb_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (fb_push) begin
                fb_valid_q <= 1'b1;
            end else if (fb_pop) begin
                fb_valid_q <= 1'b0;
            end
        end
    end

    // task and feedback payload
    always_ff @(posedge clk_i) begin
        if (task_accept) begin
            task_q <= task_i;
        end
        if (fb_push) begin
            fb_q <= fb_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/hpu_feedback_arbiter.sv
// round-robin arbiter merging the feedback of all handler controllers onto one port
`default_nettype none

module hpu_feedback_arbiter #(
    parameter int unsigned NUM_HPUS = 4
) (
    input  wire logic                                  clk_i,
    input  wire logic                                  rst_ni,

    input  wire logic [NUM_HPUS-1:0]                   fb_valid_i,
    input  wire hpu_pkg::feedback_t [NUM_HPUS-1:0]     fb_i,
    output logic      [NUM_HPUS-1:0]                   fb_ready_o,

    output logic                                       feedback_valid_o,
    input  wire logic                                  feedback_ready_i,
    output hpu_pkg::feedback_t                         feedback_o,
    output logic [(NUM_HPUS > 1 ? $clog2(NUM_HPUS) : 1)-1:0] feedback_hpu_o
);

    import hpu_pkg::*;

    localparam int unsigned IDX_W = (NUM_HPUS > 1) ? $clog2(NUM_HPUS) : 1;

    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] ptr_next;
    logic [IDX_W-1:0] rr_sel;    // free choice from the pointer
    logic [IDX_W-1:0] gnt_q;     // held grant while the output waits
    logic [IDX_W-1:0] gnt;
    logic             lock_q;
    logic             fb_xfer;
    feedback_t        gnt_fb;

    always_comb begin
        int unsigned cand;
        logic        found;
        cand   = 0;
        found  = 1'b0;
        rr_sel = '0;
        for (int unsigned i = 0; i < NUM_HPUS; i++) begin
            cand = (int'(ptr_q) + i) % NUM_HPUS;
            if (!found && fb_valid_i[cand]) begin
                found  = 1'b1;
                rr_sel = IDX_W'(cand);
            end
        end
    end

    assign gnt    = lock_q ? gnt_q : rr_sel;
    assign gnt_fb = fb_i[gnt];

    assign feedback_valid_o = fb_valid_i[gnt];
    assign feedback_o       = gnt_fb;
    assign feedback_hpu_o   = gnt;
    assign fb_xfer          = feedback_valid_o && feedback_ready_i;

    always_comb begin
        fb_ready_o = '0;
        fb_ready_o[gnt] = fb_xfer;   // pop only the granted source
    end

    always_comb begin
        if (gnt == IDX_W'(NUM_HPUS - 1)) begin
            ptr_next = '0;
        end else begin
            ptr_next = gnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q  <= '0;
            gnt_q  <= '0;
            lock_q <= 1'b0;
        end else if (fb_xfer) begin
            ptr_q  <= ptr_next;
            lock_q <= 1'b0;
        end else if (feedback_valid_o) begin
            // keep the presented descriptor until it is taken
            gnt_q  <= gnt;
            lock_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/hpu_cluster.sv
// hpu cluster top with task dispatcher, handler controllers and feedback arbiter
`default_nettype none

module hpu_cluster #(
    parameter int unsigned NUM_HPUS     = 4,
    parameter int unsigned NUM_CLUSTERS = 4
) (
    input  wire logic                                            clk_i,
    input  wire logic                                            rst_ni,

    // incoming handler tasks
    input  wire logic                                            task_valid_i,
    output logic                                                 task_ready_o,
    input  wire hpu_pkg::handler_task_t                          task_i,

    // one apb slave per hpu
    input  wire logic [NUM_HPUS-1:0]                             psel_i,
    input  wire logic [NUM_HPUS-1:0]                             penable_i,
    input  wire logic [NUM_HPUS-1:0]                             pwrite_i,
    input  wire logic [NUM_HPUS-1:0][hpu_pkg::APB_ADDR_W-1:0]    paddr_i,
    input  wire logic [NUM_HPUS-1:0][hpu_pkg::DATA_W-1:0]        pwdata_i,
    output logic      [NUM_HPUS-1:0][hpu_pkg::DATA_W-1:0]        prdata_o,
    output logic      [NUM_HPUS-1:0]                             pready_o,
    output logic      [NUM_HPUS-1:0]                             pslverr_o,

    // merged feedback
    output logic                                                 feedback_valid_o,
    input  wire logic                                            feedback_ready_i,
    output hpu_pkg::feedback_t                                   feedback_o,
    output logic [(NUM_HPUS > 1 ? $clog2(NUM_HPUS) : 1)-1:0]     feedback_hpu_o,

    output logic      [NUM_HPUS-1:0]                             hpu_active_o
);

    import hpu_pkg::*;

    logic      [NUM_HPUS-1:0] idle;
    logic      [NUM_HPUS-1:0] task_valid;
    logic      [NUM_HPUS-1:0] fb_valid;
    logic      [NUM_HPUS-1:0] fb_ready;
    feedback_t [NUM_HPUS-1:0] fb;

    hpu_task_dispatch #(
        .NUM_HPUS     (NUM_HPUS)
    ) i_dispatch (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .task_valid_i (task_valid_i),
        .task_ready_o (task_ready_o),
        .idle_i       (idle),
        .task_valid_o (task_valid)
    );

    // task bus is shared, valid goes to one controller
    for (genvar n = 0; n < NUM_HPUS; n++) begin : gen_hpu
        hpu_handler_ctrl #(
            .NUM_CLUSTERS (NUM_CLUSTERS)
        ) i_ctrl (
            .clk_i        (clk_i),
            .rst_ni       (rst_ni),
            .task_valid_i (task_valid[n]),
            .task_i       (task_i),
            .idle_o       (idle[n]),
            .active_o     (hpu_active_o[n]),
            .psel_i       (psel_i[n]),
            .penable_i    (penable_i[n]),
            .pwrite_i     (pwrite_i[n]),
            .paddr_i      (paddr_i[n]),
            .pwdata_i     (pwdata_i[n]),
            .prdata_o     (prdata_o[n]),
            .pready_o     (pready_o[n]),
            .pslverr_o    (pslverr_o[n]),
            .fb_valid_o   (fb_valid[n]),
            .fb_o         (fb[n]),
            .fb_ready_i   (fb_ready[n])
        );
    end

    hpu_feedback_arbiter #(
        .NUM_HPUS         (NUM_HPUS)
    ) i_fb_arbiter (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .fb_valid_i       (fb_valid),
        .fb_i             (fb),
        .fb_ready_o       (fb_ready),
        .feedback_valid_o (feedback_valid_o),
        .feedback_ready_i (feedback_ready_i),
        .feedback_o       (feedback_o),
        .feedback_hpu_o   (feedback_hpu_o)
    );

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
// testbench clock and reset generator
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned CLK_PERIOD_NS = 10,
    parameter int unsigned RST_CYCLES    = 10
) (
    output logic clk_o,
    output logic rst_no
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;   // released away from the active edge
    end

endmodule

`default_nettype wire

// File: verification/tb_hpu_cluster.sv
// testbench for hpu_cluster with random tasks, apb driver, reference model and watchdog
`default_nettype none

module tb_hpu_cluster;

    timeunit 1ns;
    timeprecision 100ps;

    import hpu_pkg::*;

    localparam int unsigned NUM_HPUS      = 4;
    localparam int unsigned NUM_CLUSTERS  = 4;
    localparam int unsigned IDX_W         = $clog2(NUM_HPUS);
    localparam int unsigned NUM_TASKS     = 60;
    localparam int unsigned CLK_PERIOD_NS = 10;
    localparam int unsigned WATCHDOG_NS   = (NUM_TASKS * 200 + 1000) * CLK_PERIOD_NS;
    localparam int unsigned M_INIT = 0;
    localparam int unsigned M_IDLE = 1;
    localparam int unsigned M_RUN  = 2;

    logic                                 clk_i;
    logic                                 rst_ni;
    logic                                 task_valid_i;
    logic                                 task_ready_o;
    handler_task_t                        task_i;
    logic [NUM_HPUS-1:0]                  psel_i;
    logic [NUM_HPUS-1:0]                  penable_i;
    logic [NUM_HPUS-1:0]                  pwrite_i;
    logic [NUM_HPUS-1:0][APB_ADDR_W-1:0]  paddr_i;
    logic [NUM_HPUS-1:0][DATA_W-1:0]      pwdata_i;
    logic [NUM_HPUS-1:0][DATA_W-1:0]      prdata_o;
    logic [NUM_HPUS-1:0]                  pready_o;
    logic [NUM_HPUS-1:0]                  pslverr_o;
    logic                                 feedback_valid_o;
    logic                                 feedback_ready_i;
    feedback_t                            feedback_o;
    logic [IDX_W-1:0]                     feedback_hpu_o;
    logic [NUM_HPUS-1:0]                  hpu_active_o;

    // reference model
    int unsigned   m_state [NUM_HPUS];
    handler_task_t cur_task [NUM_HPUS];
    feedback_t     exp_q [NUM_HPUS][$];   // pushed but not yet seen at the output
    int unsigned   rr_ptr;
    int unsigned   errors = 0;
    int unsigned   checks = 0;
    int unsigned   stall_left = 0;        // cycles of forced back-pressure still to go

    tb_clk_gen #(
        .CLK_PERIOD_NS (CLK_PERIOD_NS),
        .RST_CYCLES    (10)
    ) i_clk_gen (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    hpu_cluster #(
        .NUM_HPUS     (NUM_HPUS),
        .NUM_CLUSTERS (NUM_CLUSTERS)
    ) dut_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .task_valid_i     (task_valid_i),
        .task_ready_o     (task_ready_o),
        .task_i           (task_i),
        .psel_i           (psel_i),
        .penable_i        (penable_i),
        .pwrite_i         (pwrite_i),
        .paddr_i          (paddr_i),
        .pwdata_i         (pwdata_i),
        .prdata_o         (prdata_o),
        .pready_o         (pready_o),
        .pslverr_o        (pslverr_o),
        .feedback_valid_o (feedback_valid_o),
        .feedback_ready_i (feedback_ready_i),
        .feedback_o       (feedback_o),
        .feedback_hpu_o   (feedback_hpu_o),
        .hpu_active_o     (hpu_active_o)
    );

    task automatic check_eq(input string name, input logic [159:0] exp_v,
                            input logic [159:0] got_v);
        checks++;
        assert (got_v === exp_v) else begin
            errors++;
            $display("FAILED at %0t: %s expected %0h got %0h", $time, name, exp_v, got_v);
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error at %0t: %s", $time, msg);
        end
    endtask

    function automatic feedback_t feedback_of(input handler_task_t t);
        feedback_t fb;
        fb.pkt_ptr          = t.pkt_ptr;
        fb.pkt_addr         = t.pkt_addr;
        fb.msgid            = t.msgid;
        fb.pkt_size         = t.pkt_size;
        fb.trigger_feedback = t.trigger_feedback;
        return fb;
    endfunction

    function automatic logic [31:0] reg_value(input handler_task_t t, input logic [7:0] addr);
        case (addr)
            REG_HANDLER_FUN:  return t.handler_fun;
            REG_HANDLER_MEM:  return t.handler_mem_addr;
            REG_PKT_PTR:      return t.pkt_ptr;
            REG_PKT_SIZE:     return t.pkt_size;
            REG_HOST_ADDR_HI: return t.host_mem_addr[63:32];
            REG_HOST_ADDR_LO: return t.host_mem_addr[31:0];
            REG_PKT_ADDR:     return t.pkt_addr;
            REG_HOME_CLUSTER: return t.msgid % NUM_CLUSTERS;
            REG_MSGID:        return t.msgid;
            default:          return '0;
        endcase
    endfunction

    function automatic handler_task_t random_task();
        handler_task_t t;
        t.handler_fun      = ($urandom_range(4) == 0) ? 32'h0 : ($urandom | 32'h1);
        t.handler_mem_addr = $urandom;
        t.pkt_ptr          = $urandom;
        t.pkt_size         = $urandom;
        t.host_mem_addr    = {$urandom, $urandom};
        t.pkt_addr         = $urandom;
        t.msgid            = $urandom;
        t.trigger_feedback = $urandom_range(1);
        return t;
    endfunction

    // one apb transfer that starts and returns on a falling edge
    task automatic apb_xfer(input int unsigned n, input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata, input bit watch_bp,
                            output logic [31:0] rdata, output logic err);
        logic done;
        done         = 1'b0;
        psel_i[n]    = 1'b1;
        pwrite_i[n]  = wr;
        paddr_i[n]   = addr;
        pwdata_i[n]  = wdata;
        @(negedge clk_i);
        penable_i[n] = 1'b1;
        while (!done) begin
            @(posedge clk_i);
            if (watch_bp && !pready_o[n]) begin
                check_true(exp_q[n].size() > 0,
                           $sformatf("hpu %0d stalled a feedback read with no feedback queued", n));
            end else if (watch_bp) begin
                check_true(exp_q[n].size() == 0 ||
                           (feedback_valid_o && feedback_ready_i && feedback_hpu_o == n),
                           $sformatf("hpu %0d took a feedback read with its buffer full", n));
            end
            done = pready_o[n];
        end
        rdata = prdata_o[n];
        err   = pslverr_o[n];
        @(negedge clk_i);
        psel_i[n]    = 1'b0;
        penable_i[n] = 1'b0;
    endtask

    task automatic check_regs(input int unsigned n);
        logic [31:0] rdata;
        logic        err;
        logic [7:0]  addr;
        for (int unsigned a = 0; a < 9; a++) begin
            addr = 8'(a * 4);
            apb_xfer(n, 1'b0, addr, '0, 1'b0, rdata, err);
            check_eq($sformatf("pslverr_o[%0d]", n), 0, err);
            check_eq($sformatf("prdata_o[%0d] at %h", n, addr),
                     reg_value(cur_task[n], addr), rdata);
        end
        addr = 8'($urandom_range(8) * 4);
        apb_xfer(n, 1'b1, addr, $urandom, 1'b0, rdata, err);
        check_eq($sformatf("pslverr_o[%0d] on write", n), 1, err);
        addr = 8'h28 + 8'($urandom_range(53) * 4);   // past the register map
        apb_xfer(n, 1'b0, addr, '0, 1'b0, rdata, err);
        check_eq($sformatf("pslverr_o[%0d] at %h", n, addr), 1, err);
    endtask

    task automatic send_task(input handler_task_t t);
        int unsigned pred;
        int unsigned cand;
        pred = NUM_HPUS;
        for (int unsigned i = 0; i < NUM_HPUS; i++) begin
            cand = (rr_ptr + i) % NUM_HPUS;
            if (pred == NUM_HPUS && m_state[cand] == M_IDLE) begin
                pred = cand;
            end
        end
        task_valid_i = 1'b1;
        task_i       = t;
        @(posedge clk_i);
        check_true(task_ready_o, "task_ready_o low although a controller is idle");
        while (!task_ready_o) @(posedge clk_i);
        @(negedge clk_i);
        task_valid_i   = 1'b0;
        rr_ptr         = (pred + 1) % NUM_HPUS;
        cur_task[pred] = t;
        if (t.handler_fun == '0) begin
            // null handler is idle again once its descriptor sits in the buffer
            exp_q[pred].push_back(feedback_of(t));
            @(negedge clk_i);
            while (exp_q[pred].size() > 1) @(negedge clk_i);
            m_state[pred] = M_IDLE;
        end else begin
            m_state[pred] = M_RUN;
            check_regs(pred);   // msgid read confirms the routing
        end
    endtask

    task automatic finish_one();
        int unsigned start;
        int unsigned n;
        logic [31:0] rdata;
        logic        err;
        start = $urandom_range(NUM_HPUS - 1);
        n     = NUM_HPUS;
        for (int unsigned i = 0; i < NUM_HPUS; i++) begin
            if (n == NUM_HPUS && m_state[(start + i) % NUM_HPUS] == M_RUN) begin
                n = (start + i) % NUM_HPUS;
            end
        end
        apb_xfer(n, 1'b0, REG_FEEDBACK, '0, 1'b1, rdata, err);
        check_eq($sformatf("pslverr_o[%0d] on feedback", n), 0, err);
        check_eq($sformatf("prdata_o[%0d] on feedback", n), 0, rdata);
        exp_q[n].push_back(feedback_of(cur_task[n]));
        m_state[n] = M_IDLE;
    endtask

    function automatic int unsigned count_state(input int unsigned s);
        int unsigned cnt;
        cnt = 0;
        for (int unsigned i = 0; i < NUM_HPUS; i++) begin
            if (m_state[i] == s) cnt++;
        end
        return cnt;
    endfunction

    function automatic int unsigned pending();
        int unsigned cnt;
        cnt = 0;
        for (int unsigned i = 0; i < NUM_HPUS; i++) cnt += exp_q[i].size();
        return cnt;
    endfunction

    // random back-pressure with long stalls so that feedback buffers fill up
    always @(negedge clk_i) begin
        if (stall_left > 0) begin
            feedback_ready_i = 1'b0;
            stall_left--;
        end else begin
            feedback_ready_i = ($urandom_range(3) != 0);
            if ($urandom_range(63) == 0) begin
                stall_left = $urandom_range(80, 20);
            end
        end
    end

    // monitor sees the feedback port values from just before the edge
    always @(posedge clk_i) begin
        logic [IDX_W-1:0] h;
        bit               hold_valid;
        feedback_t        hold_fb;
        logic [IDX_W-1:0] hold_hpu;
        if (rst_ni) begin
            if (hold_valid) begin
                check_true(feedback_valid_o, "feedback_valid_o dropped before the handshake");
                check_eq("feedback_o held", hold_fb, feedback_o);
                check_eq("feedback_hpu_o held", hold_hpu, feedback_hpu_o);
            end
            if (feedback_valid_o && feedback_ready_i) begin
                h = feedback_hpu_o;
                if (exp_q[h].size() == 0) begin
                    check_true(1'b0, $sformatf("unexpected feedback from hpu %0d", h));
                end else begin
                    check_eq($sformatf("feedback_o from hpu %0d", h), exp_q[h][0], feedback_o);
                    void'(exp_q[h].pop_front());
                end
            end
            hold_valid = feedback_valid_o && !feedback_ready_i;
            hold_fb    = feedback_o;
            hold_hpu   = feedback_hpu_o;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, checks %0d, errors %0d", WATCHDOG_NS, checks, errors);
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [31:0] rdata;
        logic        err;
        int unsigned sent;
        void'($urandom(38));
        task_valid_i     = 1'b0;
        task_i           = '0;
        psel_i           = '0;
        penable_i        = '0;
        pwrite_i         = '0;
        paddr_i          = '0;
        pwdata_i         = '0;
        feedback_ready_i = 1'b0;
        rr_ptr           = 0;
        sent             = 0;
        for (int unsigned i = 0; i < NUM_HPUS; i++) m_state[i] = M_INIT;

        @(posedge rst_ni);
        @(negedge clk_i);
        check_eq("task_ready_o", 0, task_ready_o);
        check_eq("feedback_valid_o", 0, feedback_valid_o);
        check_eq("hpu_active_o", 0, hpu_active_o);

        // first access attaches each core
        for (int unsigned n = 0; n < NUM_HPUS; n++) begin
            apb_xfer(n, 1'b0, 8'($urandom_range(9) * 4), '0, 1'b0, rdata, err);
            check_eq($sformatf("pslverr_o[%0d] in init", n), 0, err);
            check_eq($sformatf("prdata_o[%0d] in init", n), 0, rdata);
            check_eq($sformatf("hpu_active_o[%0d]", n), 1, hpu_active_o[n]);
            m_state[n] = M_IDLE;
        end
        check_eq("task_ready_o", 1, task_ready_o);
        apb_xfer(0, 1'b0, REG_MSGID, '0, 1'b0, rdata, err);
        check_eq("pslverr_o[0] when idle", 1, err);

        while (sent < NUM_TASKS) begin
            if (count_state(M_IDLE) > 0 &&
                (count_state(M_RUN) == 0 || $urandom_range(2) != 0)) begin
                send_task(random_task());
                sent++;
            end else begin
                finish_one();
            end
        end
        while (count_state(M_RUN) > 0) finish_one();
        while (pending() > 0) @(negedge clk_i);
        repeat (5) @(negedge clk_i);
        check_true(!feedback_valid_o, "feedback_valid_o high with nothing left to send");
        for (int unsigned n = 0; n < NUM_HPUS; n++) begin
            check_true(exp_q[n].size() == 0, $sformatf("feedback of hpu %0d never arrived", n));
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hpu_cluster.f
verilog/hpu_pkg.sv
verilog/hpu_task_dispatch.sv
verilog/hpu_handler_ctrl.sv
verilog/hpu_feedback_arbiter.sv
verilog/hpu_cluster.sv
verification/tb_clk_gen.sv
verification/tb_hpu_cluster.sv

// File: Bender.yml
package:
  name: hpu_cluster

sources:
  - verilog/hpu_pkg.sv
  - verilog/hpu_task_dispatch.sv
  - verilog/hpu_handler_ctrl.sv
  - verilog/hpu_feedback_arbiter.sv
  - verilog/hpu_cluster.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_hpu_cluster.sv
